// ==== lsu.f ====
source/lsu_pkg.sv
source/biu_pkg.sv
source/lsu_addr_check.sv
source/lsu_e2m_stage.sv
source/lsu_rd_ctrl.sv
source/lsu_wr_ctrl.sv
source/lsu_load_align.sv
source/lsu_top.sv
dv/tb_clk_gen.sv
dv/lsu_props.sv
dv/tb_lsu.sv

// ==== Makefile ====
# Verilator build and run of the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= lsu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/tb_lsu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lsu
   import lsu_pkg::*, biu_pkg::*;
();

   localparam int SAMPLE_DELAY  = 10;
   localparam int REQ_TIMEOUT   = 8;
   localparam int RESET_TIMEOUT = 20;
   localparam int OPS_PER_TEST  = 40;

   logic      clk;
   logic      rst_n;
   logic      valid_e;
   lsu_op_e   lsu_op;
   gr_t       base;
   gr_t       offset;
   gr_t       wdata;
   reg_idx_t  ecl_lsu_rd_e;
   logic      ecl_lsu_wen_e;
   logic      biu_lsu_rd_ack;
   logic      biu_lsu_data_valid;
   biu_data_t biu_lsu_data;
   logic      biu_lsu_wr_ack;
   logic      biu_lsu_write_done;
   logic      lsu_biu_rd_req;
   gr_t       lsu_biu_rd_addr;
   logic      lsu_biu_wr_req;
   gr_t       lsu_biu_wr_addr;
   biu_data_t lsu_biu_wr_data;
   biu_strb_t lsu_biu_wr_strb;
   gr_t       read_result_m;
   logic      lsu_finish_m;
   reg_idx_t  lsu_ecl_rd_m;
   logic      lsu_ecl_wen_m;
   logic      lsu_ecl_ale_e;
   gr_t       lsu_csr_badv_e;

   int        test_checks;
   int        test_errors;
   int        total_checks;
   int        total_errors;
   int        tests_run;
   logic      timed_out;

   tb_clk_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   lsu_top DUT (.*);

   // write channel wants its ack in the request cycle
   assign biu_lsu_wr_ack = lsu_biu_wr_req;

   // ======================================================================
   // checking and bookkeeping
   // ======================================================================

   task automatic check_bit(input string name, input logic got, input logic exp);
      test_checks++;
      if (got !== exp) begin
         test_errors++;
         $display("** Error: %s = 0x%0h, expected 0x%0h (time %0t)", name, got, exp, $time);
      end
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      test_checks++;
      if (got !== exp) begin
         test_errors++;
         $display("** Error: %s = 0x%0h, expected 0x%0h (time %0t)", name, got, exp, $time);
      end
   endtask

   task automatic report_failure(input string what);
      test_errors++;
      $display("failure: %s (time %0t)", what, $time);
   endtask

   task automatic begin_test();
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic end_test(input string name);
      $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
      total_checks += test_checks;
      total_errors += test_errors;
      tests_run++;
   endtask

   task automatic drive_idle();
      valid_e            = 1'b0;
      biu_lsu_rd_ack     = 1'b0;
      biu_lsu_data_valid = 1'b0;
      biu_lsu_write_done = 1'b0;
   endtask

   // ======================================================================
   // reference model
   // ======================================================================

   function automatic int op_size(input lsu_op_e op);
      case (op)
         LSU_LD_B, LSU_LD_BU, LSU_ST_B: return 1;
         LSU_LD_H, LSU_LD_HU, LSU_ST_H: return 2;
         default:                       return 4;
      endcase
   endfunction

   function automatic lsu_op_e pick_misaligned_op();
      case ($urandom_range(0, 4))
         0:       return LSU_LD_H;
         1:       return LSU_LD_HU;
         2:       return LSU_LD_W;
         3:       return LSU_ST_H;
         default: return LSU_ST_W;
      endcase
   endfunction

   function automatic gr_t load_model(input lsu_op_e op, input gr_t addr, input biu_data_t beat);
      gr_t word;
      gr_t raw;
      gr_t mask;
      int  size;
      size = op_size(op);
      word = addr[2] ? beat[63:32] : beat[31:0];
      raw  = word >> {addr[1:0], 3'b000};
      if (size < 4) begin
         mask = (32'h1 << (8 * size)) - 32'h1;
         raw  = raw & mask;
         if ((op == LSU_LD_B || op == LSU_LD_H) && raw[8*size-1])
            raw = raw | ~mask;
      end
      return raw;
   endfunction

   // lane k of the chosen word carries data byte k mod size
   task automatic store_model(input lsu_op_e op, input gr_t addr, input gr_t data,
                              output biu_data_t exp_data, output biu_strb_t exp_strb);
      int size;
      int lane_off;
      int lane;
      int k;
      size     = op_size(op);
      lane_off = int'(addr[1:0]);
      exp_data = '0;
      exp_strb = '0;
      for (k = 0; k < 4; k++) begin
         lane = 4 * int'(addr[2]) + k;
         exp_data[8*lane +: 8] = data[8*(k % size) +: 8];
         if (k >= lane_off && k < lane_off + size)
            exp_strb[lane] = 1'b1;
      end
   endtask

   task automatic pick_operands(input lsu_op_e op, input logic misalign);
      gr_t addr;
      gr_t size;
      size          = gr_t'(op_size(op));
      lsu_op        = op;
      base          = $urandom;
      offset        = $urandom;
      wdata         = $urandom;
      ecl_lsu_rd_e  = reg_idx_t'($urandom);
      ecl_lsu_wen_e = 1'($urandom);
      addr          = base + offset;
      // nudge the offset onto or off the size boundary
      if (!misalign)
         offset = offset - (addr % size);
      else if (addr % size == 0)
         offset = offset + 1;
   endtask

   // ======================================================================
   // one dispatched operation, with the BIU responder
   // ======================================================================

   task automatic run_op(input lsu_op_e op, input logic misalign);
      gr_t       exp_addr;
      reg_idx_t  exp_rd;
      logic      exp_wen;
      logic      is_store;
      biu_data_t exp_data;
      biu_strb_t exp_strb;
      biu_data_t beat;
      int        ack_delay;
      int        delay;
      int        req_cycles;
      logic      acked;
      int        i;

      is_store = (op == LSU_ST_B) || (op == LSU_ST_H) || (op == LSU_ST_W);
      @(negedge clk);
      drive_idle();
      pick_operands(op, misalign);
      valid_e  = 1'b1;
      exp_addr = base + offset;
      exp_rd   = ecl_lsu_rd_e;
      exp_wen  = ecl_lsu_wen_e;
      #SAMPLE_DELAY;
      check_bit("lsu_ecl_ale_e", lsu_ecl_ale_e, misalign);
      check_bit("lsu_biu_rd_req", lsu_biu_rd_req, 1'b0);
      check_bit("lsu_biu_wr_req", lsu_biu_wr_req, is_store & ~misalign);
      check_bit("lsu_finish_m", lsu_finish_m, 1'b0);

      if (misalign) begin
         check_val("lsu_csr_badv_e", 64'(lsu_csr_badv_e), 64'(exp_addr));
         // finish is a single pulse in the next cycle
         for (i = 1; i <= 2; i++) begin
            @(negedge clk);
            drive_idle();
            #SAMPLE_DELAY;
            check_bit("lsu_finish_m", lsu_finish_m, i == 1);
            check_bit("lsu_biu_rd_req", lsu_biu_rd_req, 1'b0);
            check_bit("lsu_biu_wr_req", lsu_biu_wr_req, 1'b0);
         end
      end else if (is_store) begin
         store_model(op, exp_addr, wdata, exp_data, exp_strb);
         check_val("lsu_biu_wr_addr", 64'(lsu_biu_wr_addr), 64'(exp_addr));
         check_val("lsu_biu_wr_data", lsu_biu_wr_data, exp_data);
         check_val("lsu_biu_wr_strb", 64'(lsu_biu_wr_strb), 64'(exp_strb));
         delay = $urandom_range(1, 4);
         for (i = 1; i <= delay; i++) begin
            @(negedge clk);
            drive_idle();
            biu_lsu_write_done = (i == delay);
            #SAMPLE_DELAY;
            check_bit("lsu_biu_wr_req", lsu_biu_wr_req, 1'b0);
            check_bit("lsu_finish_m", lsu_finish_m, biu_lsu_write_done);
         end
      end else begin
         // request held from the next cycle until acked
         ack_delay  = $urandom_range(0, 3);
         req_cycles = 0;
         acked      = 1'b0;
         while (!acked && req_cycles < REQ_TIMEOUT) begin
            @(negedge clk);
            drive_idle();
            biu_lsu_rd_ack = (req_cycles >= ack_delay);
            #SAMPLE_DELAY;
            check_bit("lsu_biu_rd_req", lsu_biu_rd_req, 1'b1);
            check_val("lsu_biu_rd_addr", 64'(lsu_biu_rd_addr), 64'(exp_addr));
            check_bit("lsu_finish_m", lsu_finish_m, 1'b0);
            acked = lsu_biu_rd_req & biu_lsu_rd_ack;
            req_cycles++;
         end
         if (!acked) begin
            timed_out = 1'b1;
            report_failure("read request never completed its ack handshake");
            return;
         end
         beat  = {$urandom, $urandom};
         delay = $urandom_range(1, 4);
         for (i = 1; i <= delay; i++) begin
            @(negedge clk);
            drive_idle();
            biu_lsu_data_valid = (i == delay);
            biu_lsu_data       = (i == delay) ? beat : '0;
            #SAMPLE_DELAY;
            check_bit("lsu_biu_rd_req", lsu_biu_rd_req, 1'b0);
            check_bit("lsu_finish_m", lsu_finish_m, biu_lsu_data_valid);
         end
         check_val("read_result_m", 64'(read_result_m), 64'(load_model(op, exp_addr, beat)));
      end
      check_val("lsu_ecl_rd_m", 64'(lsu_ecl_rd_m), 64'(exp_rd));
      check_bit("lsu_ecl_wen_m", lsu_ecl_wen_m, exp_wen);
   endtask

   // ======================================================================
   // test sequence
   // ======================================================================

   initial begin
      int      waited;
      int      n;
      lsu_op_e op;
      logic    misalign;

      void'($urandom(32'h2f32));
      lsu_op        = LSU_LD_W;
      base          = '0;
      offset        = '0;
      wdata         = '0;
      ecl_lsu_rd_e  = '0;
      ecl_lsu_wen_e = 1'b0;
      biu_lsu_data  = '0;
      drive_idle();
      total_checks = 0;
      total_errors = 0;
      tests_run    = 0;
      timed_out    = 1'b0;

      begin_test();
      waited = 0;
      while (!rst_n && waited < RESET_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (!rst_n) begin
         timed_out = 1'b1;
         report_failure("reset was never released");
      end
      for (n = 0; n < 3 && !timed_out; n++) begin
         @(negedge clk);
         #SAMPLE_DELAY;
         check_bit("lsu_biu_rd_req", lsu_biu_rd_req, 1'b0);
         check_bit("lsu_biu_wr_req", lsu_biu_wr_req, 1'b0);
         check_bit("lsu_finish_m", lsu_finish_m, 1'b0);
      end
      end_test("reset state");

      begin_test();
      for (n = 0; n < OPS_PER_TEST && !timed_out; n++)
         run_op(lsu_op_e'($urandom_range(0, 4)), 1'b0);
      end_test("aligned loads");

      begin_test();
      for (n = 0; n < OPS_PER_TEST && !timed_out; n++)
         run_op(lsu_op_e'($urandom_range(5, 7)), 1'b0);
      end_test("aligned stores");

      begin_test();
      for (n = 0; n < OPS_PER_TEST && !timed_out; n++)
         run_op(pick_misaligned_op(), 1'b1);
      end_test("misaligned accesses");

      // loads and stores interleaved with some faulting ones
      begin_test();
      for (n = 0; n < OPS_PER_TEST && !timed_out; n++) begin
         op       = lsu_op_e'($urandom_range(0, 7));
         misalign = (op_size(op) > 1) && ($urandom_range(0, 3) == 0);
         run_op(op, misalign);
      end
      end_test("mixed traffic");

      $display("summary: %0d tests, %0d checks, %0d errors", tests_run, total_checks,
               total_errors);
      if (total_errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/lsu_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_props
   import lsu_pkg::*;
(
   input logic clk,
   input logic rst_n,
   input logic req,
   input gr_t  addr,
   input logic ack,
   input logic done
);

   logic busy_q;

   // transfer seen at the ports from its accepted request to its done
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
      end else if (req && ack) begin
         busy_q <= 1'b1;
      end else if (done) begin
         busy_q <= 1'b0;
      end
   end

   // one transfer outstanding per channel
   assert property (@(posedge clk) disable iff (!rst_n) busy_q |-> !req)
      else $error("request raised while a transfer is in progress");

   // request held with a steady address until the BIU takes it
   assert property (@(posedge clk) disable iff (!rst_n) (req && !ack) |=> (req && $stable(addr)))
      else $error("request dropped or address changed before the ack");

endmodule

bind lsu_rd_ctrl lsu_props u_rd_props (
   .clk   (clk),
   .rst_n (rst_n),
   .req   (lsu_biu_rd_req),
   .addr  (lsu_biu_rd_addr),
   .ack   (biu_lsu_rd_ack),
   .done  (biu_lsu_data_valid)
);

bind lsu_wr_ctrl lsu_props u_wr_props (
   .clk   (clk),
   .rst_n (rst_n),
   .req   (lsu_biu_wr_req),
   .addr  (lsu_biu_wr_addr),
   .ack   (biu_lsu_wr_ack),
   .done  (biu_lsu_write_done)
);

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   localparam int HALF_PERIOD  = 20;
   localparam int RESET_CYCLES = 5;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // release on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_top
   import lsu_pkg::*, biu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   // execute side
   input  logic      valid_e,
   input  lsu_op_e   lsu_op,
   input  gr_t       base,
   input  gr_t       offset,
   input  gr_t       wdata,
   input  reg_idx_t  ecl_lsu_rd_e,
   input  logic      ecl_lsu_wen_e,

   // BIU responses
   input  logic      biu_lsu_rd_ack,
   input  logic      biu_lsu_data_valid,
   input  biu_data_t biu_lsu_data,
   input  logic      biu_lsu_wr_ack,
   input  logic      biu_lsu_write_done,

   // BIU requests
   output logic      lsu_biu_rd_req,
   output gr_t       lsu_biu_rd_addr,
   output logic      lsu_biu_wr_req,
   output gr_t       lsu_biu_wr_addr,
   output biu_data_t lsu_biu_wr_data,
   output biu_strb_t lsu_biu_wr_strb,

   // results
   output gr_t       read_result_m,
   output logic      lsu_finish_m,
   output reg_idx_t  lsu_ecl_rd_m,
   output logic      lsu_ecl_wen_m,
   output logic      lsu_ecl_ale_e,
   output gr_t       lsu_csr_badv_e
);

   gr_t     addr_e;
   gr_t     addr_m;
   logic    is_store_e;
   logic    is_store_m;
   logic    valid_val_e;
   lsu_op_e lsu_op_m;

   lsu_addr_check u_addr_check (
      .valid_e        (valid_e),
      .lsu_op         (lsu_op),
      .base           (base),
      .offset         (offset),
      .addr_e         (addr_e),
      .is_store_e     (is_store_e),
      .valid_val_e    (valid_val_e),
      .lsu_ecl_ale_e  (lsu_ecl_ale_e),
      .lsu_csr_badv_e (lsu_csr_badv_e)
   );

   lsu_e2m_stage u_e2m_stage (
      .clk                (clk),
      .rst_n              (rst_n),
      .valid_e            (valid_e),
      .lsu_op             (lsu_op),
      .addr_e             (addr_e),
      .is_store_e         (is_store_e),
      .lsu_ecl_ale_e      (lsu_ecl_ale_e),
      .ecl_lsu_rd_e       (ecl_lsu_rd_e),
      .ecl_lsu_wen_e      (ecl_lsu_wen_e),
      .biu_lsu_data_valid (biu_lsu_data_valid),
      .biu_lsu_write_done (biu_lsu_write_done),
      .lsu_op_m           (lsu_op_m),
      .addr_m             (addr_m),
      .is_store_m         (is_store_m),
      .lsu_finish_m       (lsu_finish_m),
      .lsu_ecl_rd_m       (lsu_ecl_rd_m),
      .lsu_ecl_wen_m      (lsu_ecl_wen_m)
   );

   lsu_rd_ctrl u_rd_ctrl (
      .clk                (clk),
      .rst_n              (rst_n),
      .valid_val_e        (valid_val_e),
      .is_store_m         (is_store_m),
      .addr_m             (addr_m),
      .biu_lsu_rd_ack     (biu_lsu_rd_ack),
      .biu_lsu_wr_ack     (biu_lsu_wr_ack),
      .biu_lsu_data_valid (biu_lsu_data_valid),
      .lsu_biu_rd_req     (lsu_biu_rd_req),
      .lsu_biu_rd_addr    (lsu_biu_rd_addr)
   );

   lsu_wr_ctrl u_wr_ctrl (
      .clk                (clk),
      .rst_n              (rst_n),
      .valid_val_e        (valid_val_e),
      .is_store_e         (is_store_e),
      .lsu_op             (lsu_op),
      .addr_e             (addr_e),
      .wdata              (wdata),
      .biu_lsu_wr_ack     (biu_lsu_wr_ack),
      .biu_lsu_write_done (biu_lsu_write_done),
      .lsu_biu_wr_req     (lsu_biu_wr_req),
      .lsu_biu_wr_addr    (lsu_biu_wr_addr),
      .lsu_biu_wr_data    (lsu_biu_wr_data),
      .lsu_biu_wr_strb    (lsu_biu_wr_strb)
   );

   lsu_load_align u_load_align (
      .lsu_op_m      (lsu_op_m),
      .addr_m        (addr_m),
      .biu_lsu_data  (biu_lsu_data),
      .read_result_m (read_result_m)
   );

endmodule

`default_nettype wire

// ==== source/lsu_load_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_load_align
   import lsu_pkg::*, biu_pkg::*;
(
   input  lsu_op_e   lsu_op_m,
   input  gr_t       addr_m,
   input  biu_data_t biu_lsu_data,
   output gr_t       read_result_m
);

   gr_t         rd_word;
   logic [7:0]  rd_byte;
   logic [15:0] rd_half;

   // upper or lower word of the beat
   assign rd_word = addr_m[2] ? biu_lsu_data[63:32] : biu_lsu_data[31:0];

   always_comb begin
      case (addr_m[1:0])
         2'b00:   rd_byte = rd_word[7:0];
         2'b01:   rd_byte = rd_word[15:8];
         2'b10:   rd_byte = rd_word[23:16];
         default: rd_byte = rd_word[31:24];
      endcase
   end

   // halves are aligned, so bit 1 alone picks one
   assign rd_half = addr_m[1] ? rd_word[31:16] : rd_word[15:0];

   // sign or zero extend
   always_comb begin
      case (lsu_op_m)
         LSU_LD_B:  read_result_m = {{24{rd_byte[7]}}, rd_byte};
         LSU_LD_BU: read_result_m = {24'b0, rd_byte};
         LSU_LD_H:  read_result_m = {{16{rd_half[15]}}, rd_half};
         LSU_LD_HU: read_result_m = {16'b0, rd_half};
         default:   read_result_m = rd_word;
      endcase
   end

endmodule

`default_nettype wire

// ==== source/lsu_wr_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_wr_ctrl
   import lsu_pkg::*, biu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      valid_val_e,
   input  logic      is_store_e,
   input  lsu_op_e   lsu_op,
   input  gr_t       addr_e,
   input  gr_t       wdata,
   input  logic      biu_lsu_wr_ack,
   input  logic      biu_lsu_write_done,
   output logic      lsu_biu_wr_req,
   output gr_t       lsu_biu_wr_addr,
   output biu_data_t lsu_biu_wr_data,
   output biu_strb_t lsu_biu_wr_strb
);

   gr_t        st_word;
   word_strb_t st_strb;
   logic       wr_in_prog_q;

   // data copied to every lane, strobe picks the lanes
   always_comb begin
      st_word = '0;
      st_strb = '0;
      case (lsu_op)
         LSU_ST_B: begin
            st_word = {4{wdata[7:0]}};
            st_strb = word_strb_t'(4'b0001 << addr_e[1:0]);
         end
         LSU_ST_H: begin
            st_word = {2{wdata[15:0]}};
            st_strb = word_strb_t'(4'b0011 << addr_e[1:0]);
         end
         LSU_ST_W: begin
            st_word = wdata;
            st_strb = 4'b1111;
         end
         default: ;
      endcase
   end

   // address bit 2 selects the half of the beat
   assign lsu_biu_wr_data = addr_e[2] ? {st_word, 32'b0} : {32'b0, st_word};
   assign lsu_biu_wr_strb = addr_e[2] ? {st_strb, 4'b0} : {4'b0, st_strb};
   assign lsu_biu_wr_addr = addr_e;

   // BIU acks in the request cycle, done comes later
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_in_prog_q <= 1'b0;
      end else begin
         wr_in_prog_q <= (wr_in_prog_q & ~biu_lsu_write_done) | biu_lsu_wr_ack;
      end
   end

   assign lsu_biu_wr_req = valid_val_e & is_store_e & ~wr_in_prog_q;

endmodule

`default_nettype wire

// ==== source/lsu_rd_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_rd_ctrl
   import lsu_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic valid_val_e,
   input  logic is_store_m,
   input  gr_t  addr_m,
   input  logic biu_lsu_rd_ack,
   input  logic biu_lsu_wr_ack,
   input  logic biu_lsu_data_valid,
   output logic lsu_biu_rd_req,
   output gr_t  lsu_biu_rd_addr
);

   logic valid_val_m;
   logic rd_in_prog_q;

   // ======================================================================
   // held request valid, dropped once the BIU has taken the request
   // ======================================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_val_m <= 1'b0;
      end else if (biu_lsu_rd_ack | biu_lsu_wr_ack) begin
         valid_val_m <= 1'b0;
      end else if (valid_val_e) begin
         valid_val_m <= 1'b1;
      end
   end

   // set after the ack, cleared after data returns
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_in_prog_q <= 1'b0;
      end else begin
         rd_in_prog_q <= (rd_in_prog_q & ~biu_lsu_data_valid) | biu_lsu_rd_ack;
      end
   end

   assign lsu_biu_rd_req  = valid_val_m & ~is_store_m & ~rd_in_prog_q;
   assign lsu_biu_rd_addr = addr_m;

endmodule

`default_nettype wire

// ==== source/lsu_e2m_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_e2m_stage
   import lsu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     valid_e,
   input  lsu_op_e  lsu_op,
   input  gr_t      addr_e,
   input  logic     is_store_e,
   input  logic     lsu_ecl_ale_e,
   input  reg_idx_t ecl_lsu_rd_e,
   input  logic     ecl_lsu_wen_e,
   input  logic     biu_lsu_data_valid,
   input  logic     biu_lsu_write_done,
   output lsu_op_e  lsu_op_m,
   output gr_t      addr_m,
   output logic     is_store_m,
   output logic     lsu_finish_m,
   output reg_idx_t lsu_ecl_rd_m,
   output logic     lsu_ecl_wen_m
);

   logic ale_m;

   // payload, held until the next dispatch
   always_ff @(posedge clk) begin
      if (valid_e) begin
         lsu_op_m     <= lsu_op;
         addr_m       <= addr_e;
         lsu_ecl_rd_m <= ecl_lsu_rd_e;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         is_store_m    <= 1'b0;
         lsu_ecl_wen_m <= 1'b0;
         ale_m         <= 1'b0;
      end else begin
         // single cycle pulse, the faulting op sends no request
         ale_m <= lsu_ecl_ale_e;
         if (valid_e) begin
            is_store_m    <= is_store_e;
            lsu_ecl_wen_m <= ecl_lsu_wen_e;
         end
      end
   end

   assign lsu_finish_m = biu_lsu_data_valid | biu_lsu_write_done | ale_m;

endmodule

`default_nettype wire

// ==== source/lsu_addr_check.sv ====
`timescale 1ns/100ps
`default_nettype none

module lsu_addr_check
   import lsu_pkg::*;
(
   input  logic    valid_e,
   input  lsu_op_e lsu_op,
   input  gr_t     base,
   input  gr_t     offset,
   output gr_t     addr_e,
   output logic    is_store_e,
   output logic    valid_val_e,
   output logic    lsu_ecl_ale_e,
   output gr_t     lsu_csr_badv_e
);

   logic is_half;
   logic is_word;
   logic ale;

   assign addr_e = base + offset;

   // store flag and access size
   always_comb begin
      is_store_e = 1'b0;
      is_half    = 1'b0;
      is_word    = 1'b0;
      case (lsu_op)
         LSU_LD_H, LSU_LD_HU: is_half = 1'b1;
         LSU_LD_W:            is_word = 1'b1;
         LSU_ST_B:            is_store_e = 1'b1;
         LSU_ST_H: begin
            is_store_e = 1'b1;
            is_half    = 1'b1;
         end
         LSU_ST_W: begin
            is_store_e = 1'b1;
            is_word    = 1'b1;
         end
         default: ;
      endcase
   end

   // byte accesses never fault
   assign ale = (is_half & addr_e[0]) | (is_word & (addr_e[1:0] != 2'b00));

   assign valid_val_e    = valid_e & ~ale;
   assign lsu_ecl_ale_e  = valid_e & ale;
   assign lsu_csr_badv_e = addr_e;

endmodule

`default_nettype wire

// ==== source/biu_pkg.sv ====
`default_nettype none

package biu_pkg;

   // one data beat on either BIU channel
   localparam int BIU_DATA_W = 64;
   localparam int BIU_STRB_W = BIU_DATA_W / 8;

   typedef logic [BIU_DATA_W-1:0]   biu_data_t;
   typedef logic [BIU_STRB_W-1:0]   biu_strb_t;
   // byte enables of one 32-bit half of the beat
   typedef logic [BIU_STRB_W/2-1:0] word_strb_t;

endpackage

`default_nettype wire

// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // ======================================================================
   // general register and register index
   // ======================================================================

   localparam int GRLEN     = 32;
   localparam int REG_IDX_W = 5;

   typedef logic [GRLEN-1:0]     gr_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // ======================================================================
   // memory operation codes
   // ======================================================================

   localparam int LSU_OP_W = 4;

   // codes 8..15 are illegal, decoded as neither load nor store
   typedef enum logic [LSU_OP_W-1:0] {
      LSU_LD_B  = 4'h0,
      LSU_LD_H  = 4'h1,
      LSU_LD_W  = 4'h2,
      LSU_LD_BU = 4'h3,
      LSU_LD_HU = 4'h4,
      LSU_ST_B  = 4'h5,
      LSU_ST_H  = 4'h6,
      LSU_ST_W  = 4'h7
   } lsu_op_e;

endpackage

`default_nettype wire
